//--- rtl/task_unit_pkg.sv
package task_unit_pkg;

   // Queue geometry
   localparam int LOG_TQ_SIZE = 4;
   localparam int TQ_DEPTH    = 1 << LOG_TQ_SIZE;

   // Task word layout: type, args, hint, timestamp from msb down
   localparam int TASK_W    = 72;
   localparam int TTYPE_LSB = 68;

   typedef logic [TASK_W-1:0]      task_t;
   typedef logic [3:0]             ttype_t;
   typedef logic [LOG_TQ_SIZE:0]   tq_count_t;
   typedef logic [7:0]             spill_cnt_t;
   typedef logic [31:0]            reg_t;
   typedef logic [3:0]             reg_addr_t;

   localparam ttype_t TASK_TYPE_SPLITTER = 4'hF;

   // Register map
   localparam reg_addr_t REG_SPILL_THRESHOLD    = 4'd0;
   localparam reg_addr_t REG_SPILL_SIZE         = 4'd1;
   localparam reg_addr_t REG_N_TASKS            = 4'd2;
   localparam reg_addr_t REG_N_ENQ              = 4'd3;
   localparam reg_addr_t REG_N_DEQ              = 4'd4;
   localparam reg_addr_t REG_N_SPLITTER_DEQ     = 4'd5;
   localparam reg_addr_t REG_N_COAL_CHILD       = 4'd6;
   localparam reg_addr_t REG_N_OVERFLOW         = 4'd7;
   localparam reg_addr_t REG_N_CYCLES_DEQ_VALID = 4'd8;

   localparam tq_count_t  DEFAULT_SPILL_THRESHOLD = 5'd12;
   localparam spill_cnt_t DEFAULT_SPILL_SIZE      = 8'd4;

   typedef enum logic {
      SPILL_IDLE,
      SPILL_ACTIVE
   } spill_state_t;

endpackage

//--- rtl/task_queue.sv
`timescale 1ns/1ps

module task_queue import task_unit_pkg::*; (
   input  logic      clk,
   input  logic      rstn,
   input  logic      coal_child_valid,
   output logic      coal_child_ready,
   input  task_t     coal_child_data,
   input  logic      task_enq_valid,
   output logic      task_enq_ready,
   input  task_t     task_enq_data,
   input  logic      head_pop,
   input  tq_count_t spill_threshold,
   output task_t     head_task,
   output logic      head_valid,
   output logic      empty,
   output tq_count_t n_tasks,
   output logic      full,
   output logic      almost_full
);

   task_t                  mem [TQ_DEPTH];
   logic [LOG_TQ_SIZE-1:0] wr_ptr;
   logic [LOG_TQ_SIZE-1:0] rd_ptr;
   tq_count_t              count;
   logic                   wr_en;
   task_t                  wr_data;

   assign full        = (count == tq_count_t'(TQ_DEPTH));
   assign almost_full = (count > spill_threshold);
   assign head_valid  = (count != '0);
   assign empty       = !head_valid;
   assign n_tasks     = count;
   assign head_task   = mem[rd_ptr];

   // Coalescer children always win over normal enqueues
   assign coal_child_ready = !full;
   assign task_enq_ready   = !full && !almost_full && !coal_child_valid;

   assign wr_en   = (coal_child_valid && coal_child_ready) ||
                    (task_enq_valid && task_enq_ready);
   assign wr_data = coal_child_valid ? coal_child_data : task_enq_data;

   always_ff @(posedge clk) begin
      if (wr_en) begin
         mem[wr_ptr] <= wr_data;
      end
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (wr_en) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (head_pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({wr_en, head_pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

endmodule

//--- rtl/task_dispatch.sv
`timescale 1ns/1ps

module task_dispatch import task_unit_pkg::*; (
   input  logic       clk,
   input  logic       rstn,
   input  task_t      head_task,
   input  logic       head_valid,
   input  logic       almost_full,
   input  spill_cnt_t spill_size,
   output logic       overflow_valid,
   input  logic       overflow_ready,
   output task_t      overflow_data,
   output logic       task_deq_valid,
   input  logic       task_deq_ready,
   output task_t      task_deq_data,
   output logic       splitter_deq_valid,
   input  logic       splitter_deq_ready,
   output task_t      splitter_deq_task,
   output logic       head_pop
);

   spill_state_t spill_state;
   spill_cnt_t   spills_left;
   ttype_t       head_ttype;
   logic         is_splitter;
   logic         ovf_xfer;

   assign head_ttype  = head_task[TTYPE_LSB +: 4];
   assign is_splitter = (head_ttype == TASK_TYPE_SPLITTER);

   // While spilling only the overflow port sees the head
   assign overflow_valid     = head_valid && (spill_state == SPILL_ACTIVE);
   assign task_deq_valid     = head_valid && (spill_state == SPILL_IDLE) && !is_splitter;
   assign splitter_deq_valid = head_valid && (spill_state == SPILL_IDLE) && is_splitter;

   assign overflow_data     = head_task;
   assign task_deq_data     = head_task;
   assign splitter_deq_task = head_task;

   assign ovf_xfer = overflow_valid && overflow_ready;
   assign head_pop = ovf_xfer || (task_deq_valid && task_deq_ready) ||
                     (splitter_deq_valid && splitter_deq_ready);

   always_ff @(posedge clk) begin
      if (!rstn) begin
         spill_state <= SPILL_IDLE;
         spills_left <= '0;
      end else begin
         case (spill_state)
            SPILL_IDLE: begin
               if (almost_full && (spill_size != '0)) begin
                  spill_state <= SPILL_ACTIVE;
                  spills_left <= spill_size;
               end
            end
            SPILL_ACTIVE: begin
               if (ovf_xfer) begin
                  spills_left <= spills_left - 1'b1;
                  // Last task of this spill burst
                  if (spills_left == spill_cnt_t'(1)) begin
                     spill_state <= SPILL_IDLE;
                  end
               end
            end
            default: spill_state <= SPILL_IDLE;
         endcase
      end
   end

endmodule

//--- rtl/task_stats.sv
`timescale 1ns/1ps

module task_stats import task_unit_pkg::*; (
   input  logic clk,
   input  logic rstn,
   input  logic task_enq_valid,
   input  logic task_enq_ready,
   input  logic coal_child_valid,
   input  logic coal_child_ready,
   input  logic task_deq_valid,
   input  logic task_deq_ready,
   input  logic splitter_deq_valid,
   input  logic splitter_deq_ready,
   input  logic overflow_valid,
   input  logic overflow_ready,
   output reg_t n_enq,
   output reg_t n_coal_child,
   output reg_t n_deq,
   output reg_t n_splitter_deq,
   output reg_t n_overflow,
   output reg_t n_cycles_deq_valid
);

   always_ff @(posedge clk) begin
      if (!rstn) begin
         n_enq              <= '0;
         n_coal_child       <= '0;
         n_deq              <= '0;
         n_splitter_deq     <= '0;
         n_overflow         <= '0;
         n_cycles_deq_valid <= '0;
      end else begin
         if (task_enq_valid && task_enq_ready) begin
            n_enq <= n_enq + 1'b1;
         end
         if (coal_child_valid && coal_child_ready) begin
            n_coal_child <= n_coal_child + 1'b1;
         end
         if (task_deq_valid && task_deq_ready) begin
            n_deq <= n_deq + 1'b1;
         end
         if (splitter_deq_valid && splitter_deq_ready) begin
            n_splitter_deq <= n_splitter_deq + 1'b1;
         end
         if (overflow_valid && overflow_ready) begin
            n_overflow <= n_overflow + 1'b1;
         end
         // Counts stalled cycles too
         if (task_deq_valid) begin
            n_cycles_deq_valid <= n_cycles_deq_valid + 1'b1;
         end
      end
   end

endmodule

//--- rtl/task_unit_csr.sv
`timescale 1ns/1ps

module task_unit_csr import task_unit_pkg::*; (
   input  logic       clk,
   input  logic       rstn,
   input  logic       wb_cyc,
   input  logic       wb_stb,
   input  logic       wb_we,
   input  reg_addr_t  wb_adr,
   input  reg_t       wb_wdata,
   output reg_t       wb_rdata,
   output logic       wb_ack,
   input  tq_count_t  n_tasks,
   input  reg_t       n_enq,
   input  reg_t       n_coal_child,
   input  reg_t       n_deq,
   input  reg_t       n_splitter_deq,
   input  reg_t       n_overflow,
   input  reg_t       n_cycles_deq_valid,
   output tq_count_t  spill_threshold,
   output spill_cnt_t spill_size
);

   logic access;
   reg_t rd_value;

   // New access only while ack is low, so each one acks once
   assign access = wb_cyc && wb_stb && !wb_ack;

   always_comb begin
      case (wb_adr)
         REG_SPILL_THRESHOLD:    rd_value = reg_t'(spill_threshold);
         REG_SPILL_SIZE:         rd_value = reg_t'(spill_size);
         REG_N_TASKS:            rd_value = reg_t'(n_tasks);
         REG_N_ENQ:              rd_value = n_enq;
         REG_N_DEQ:              rd_value = n_deq;
         REG_N_SPLITTER_DEQ:     rd_value = n_splitter_deq;
         REG_N_COAL_CHILD:       rd_value = n_coal_child;
         REG_N_OVERFLOW:         rd_value = n_overflow;
         REG_N_CYCLES_DEQ_VALID: rd_value = n_cycles_deq_valid;
         default:                rd_value = '0;
      endcase
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         wb_ack          <= 1'b0;
         spill_threshold <= DEFAULT_SPILL_THRESHOLD;
         spill_size      <= DEFAULT_SPILL_SIZE;
      end else begin
         wb_ack <= access;
         if (access && wb_we) begin
            case (wb_adr)
               REG_SPILL_THRESHOLD: spill_threshold <= wb_wdata[LOG_TQ_SIZE:0];
               REG_SPILL_SIZE:      spill_size <= wb_wdata[7:0];
               default:             ;
            endcase
         end
      end
   end

   always_ff @(posedge clk) begin
      if (access && !wb_we) begin
         wb_rdata <= rd_value;
      end
   end

endmodule

//--- rtl/task_unit.sv
`timescale 1ns/1ps

module task_unit import task_unit_pkg::*; (
   input  logic      clk,
   input  logic      rstn,

   // Task sources
   input  logic      task_enq_valid,
   output logic      task_enq_ready,
   input  task_t     task_enq_data,
   input  logic      coal_child_valid,
   output logic      coal_child_ready,
   input  task_t     coal_child_data,

   // Task sinks
   output logic      task_deq_valid,
   input  logic      task_deq_ready,
   output task_t     task_deq_data,
   output logic      splitter_deq_valid,
   input  logic      splitter_deq_ready,
   output task_t     splitter_deq_task,
   output logic      overflow_valid,
   input  logic      overflow_ready,
   output task_t     overflow_data,

   output logic      full,
   output logic      almost_full,
   output logic      empty,

   // Wishbone register slave
   input  logic      wb_cyc,
   input  logic      wb_stb,
   input  logic      wb_we,
   input  reg_addr_t wb_adr,
   input  reg_t      wb_wdata,
   output reg_t      wb_rdata,
   output logic      wb_ack
);

   task_t      head_task;
   logic       head_valid;
   logic       head_pop;
   tq_count_t  n_tasks;
   tq_count_t  spill_threshold;
   spill_cnt_t spill_size;
   reg_t       n_enq;
   reg_t       n_coal_child;
   reg_t       n_deq;
   reg_t       n_splitter_deq;
   reg_t       n_overflow;
   reg_t       n_cycles_deq_valid;

   task_queue u_queue (
      .clk              (clk),
      .rstn             (rstn),
      .coal_child_valid (coal_child_valid),
      .coal_child_ready (coal_child_ready),
      .coal_child_data  (coal_child_data),
      .task_enq_valid   (task_enq_valid),
      .task_enq_ready   (task_enq_ready),
      .task_enq_data    (task_enq_data),
      .head_pop         (head_pop),
      .spill_threshold  (spill_threshold),
      .head_task        (head_task),
      .head_valid       (head_valid),
      .empty            (empty),
      .n_tasks          (n_tasks),
      .full             (full),
      .almost_full      (almost_full)
   );

   task_dispatch u_dispatch (
      .clk                (clk),
      .rstn               (rstn),
      .head_task          (head_task),
      .head_valid         (head_valid),
      .almost_full        (almost_full),
      .spill_size         (spill_size),
      .overflow_valid     (overflow_valid),
      .overflow_ready     (overflow_ready),
      .overflow_data      (overflow_data),
      .task_deq_valid     (task_deq_valid),
      .task_deq_ready     (task_deq_ready),
      .task_deq_data      (task_deq_data),
      .splitter_deq_valid (splitter_deq_valid),
      .splitter_deq_ready (splitter_deq_ready),
      .splitter_deq_task  (splitter_deq_task),
      .head_pop           (head_pop)
   );

   task_stats u_stats (
      .clk                (clk),
      .rstn               (rstn),
      .task_enq_valid     (task_enq_valid),
      .task_enq_ready     (task_enq_ready),
      .coal_child_valid   (coal_child_valid),
      .coal_child_ready   (coal_child_ready),
      .task_deq_valid     (task_deq_valid),
      .task_deq_ready     (task_deq_ready),
      .splitter_deq_valid (splitter_deq_valid),
      .splitter_deq_ready (splitter_deq_ready),
      .overflow_valid     (overflow_valid),
      .overflow_ready     (overflow_ready),
      .n_enq              (n_enq),
      .n_coal_child       (n_coal_child),
      .n_deq              (n_deq),
      .n_splitter_deq     (n_splitter_deq),
      .n_overflow         (n_overflow),
      .n_cycles_deq_valid (n_cycles_deq_valid)
   );

   task_unit_csr u_csr (
      .clk                (clk),
      .rstn               (rstn),
      .wb_cyc             (wb_cyc),
      .wb_stb             (wb_stb),
      .wb_we              (wb_we),
      .wb_adr             (wb_adr),
      .wb_wdata           (wb_wdata),
      .wb_rdata           (wb_rdata),
      .wb_ack             (wb_ack),
      .n_tasks            (n_tasks),
      .n_enq              (n_enq),
      .n_coal_child       (n_coal_child),
      .n_deq              (n_deq),
      .n_splitter_deq     (n_splitter_deq),
      .n_overflow         (n_overflow),
      .n_cycles_deq_valid (n_cycles_deq_valid),
      .spill_threshold    (spill_threshold),
      .spill_size         (spill_size)
   );

endmodule

//--- test/task_unit_chk.sv
`timescale 1ns/1ps

module task_unit_chk import task_unit_pkg::*; (
   input logic         clk,
   input logic         rstn,
   input logic         task_enq_ready,
   input logic         almost_full,
   input logic         empty,
   input logic         overflow_valid,
   input logic         overflow_ready,
   input task_t        overflow_data,
   input logic         task_deq_valid,
   input logic         task_deq_ready,
   input task_t        task_deq_data,
   input logic         splitter_deq_valid,
   input logic         splitter_deq_ready,
   input task_t        splitter_deq_task,
   input logic         wb_ack,
   input spill_state_t spill_state
);

   a_one_valid: assert property (@(posedge clk) disable iff (!rstn)
      $onehot0({overflow_valid, task_deq_valid, splitter_deq_valid}))
      else $error("More than one task output valid in the same cycle");

   a_empty_quiet: assert property (@(posedge clk) disable iff (!rstn)
      empty |-> !(overflow_valid || task_deq_valid || splitter_deq_valid))
      else $error("Task output valid while the queue is empty");

   a_enq_blocked: assert property (@(posedge clk) disable iff (!rstn)
      almost_full |-> !task_enq_ready)
      else $error("Enqueue ready while the queue is almost full");

   a_ack_pulse: assert property (@(posedge clk) disable iff (!rstn)
      wb_ack |=> !wb_ack)
      else $error("Wishbone ack high for two cycles in a row");

   a_ovf_stall: assert property (@(posedge clk) disable iff (!rstn)
      overflow_valid && !overflow_ready |=> overflow_valid && $stable(overflow_data))
      else $error("Stalled overflow task dropped or changed");

   // A spill that starts may move a stalled head over to overflow
   a_deq_stall: assert property (@(posedge clk) disable iff (!rstn)
      task_deq_valid && !task_deq_ready
      |=> spill_state == SPILL_ACTIVE || (task_deq_valid && $stable(task_deq_data)))
      else $error("Stalled dequeue task dropped or changed");

   a_spl_stall: assert property (@(posedge clk) disable iff (!rstn)
      splitter_deq_valid && !splitter_deq_ready
      |=> spill_state == SPILL_ACTIVE ||
          (splitter_deq_valid && $stable(splitter_deq_task)))
      else $error("Stalled splitter task dropped or changed");

endmodule

bind task_unit task_unit_chk u_chk (
   .*,
   .spill_state (u_dispatch.spill_state)
);

//--- test/task_unit_tb.sv
`timescale 1ns/1ps

module task_unit_tb import task_unit_pkg::*; ();

   typedef enum logic [2:0] {
      OP_PUSH,
      OP_CHILD,
      OP_BOTH,
      OP_DRAIN,
      OP_WRITE,
      OP_READ,
      OP_READ_MODEL
   } op_t;

   // n is a repeat or drain count, val a splitter mask, ready pattern or register value
   typedef struct packed {
      op_t        op;
      logic [7:0] n;
      reg_addr_t  adr;
      reg_t       val;
   } row_t;

   logic      clk;
   logic      rstn;
   logic      task_enq_valid;
   logic      task_enq_ready;
   task_t     task_enq_data;
   logic      coal_child_valid;
   logic      coal_child_ready;
   task_t     coal_child_data;
   logic      task_deq_valid;
   logic      task_deq_ready;
   task_t     task_deq_data;
   logic      splitter_deq_valid;
   logic      splitter_deq_ready;
   task_t     splitter_deq_task;
   logic      overflow_valid;
   logic      overflow_ready;
   task_t     overflow_data;
   logic      full;
   logic      almost_full;
   logic      empty;
   logic      wb_cyc;
   logic      wb_stb;
   logic      wb_we;
   reg_addr_t wb_adr;
   reg_t      wb_wdata;
   reg_t      wb_rdata;
   logic      wb_ack;

   row_t        rows[$];
   logic        rows_built;
   logic [31:0] lfsr_state;
   int          n_checks;
   int          n_errors;

   // Reference model state
   task_t m_q[$];
   logic  m_spill;
   int    m_left;
   int    m_thr;
   int    m_size;
   logic  m_ack;
   reg_t  m_rd_exp;
   int    m_popped;
   reg_t  m_n_enq;
   reg_t  m_n_child;
   reg_t  m_n_deq;
   reg_t  m_n_spl;
   reg_t  m_n_ovf;
   reg_t  m_n_dvc;

   task_unit DUT (.*);

   always #20 clk = !clk;

   function automatic logic next_rand_bit();
      lfsr_state = {lfsr_state[30:0],
                    lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
      return lfsr_state[0];
   endfunction

   function automatic task_t gen_word(input logic splitter);
      task_t w;
      w = '0;
      for (int i = 0; i < TASK_W; i++) begin
         w = {w[TASK_W-2:0], next_rand_bit()};
      end
      // Ordinary tasks never carry type F
      if (splitter)
         w[71:68] = 4'hF;
      else
         w[71] = 1'b0;
      return w;
   endfunction

   function automatic reg_t model_reg(input reg_addr_t adr);
      case (adr)
         REG_SPILL_THRESHOLD:    return reg_t'(m_thr);
         REG_SPILL_SIZE:         return reg_t'(m_size);
         REG_N_TASKS:            return reg_t'(m_q.size());
         REG_N_ENQ:              return m_n_enq;
         REG_N_DEQ:              return m_n_deq;
         REG_N_SPLITTER_DEQ:     return m_n_spl;
         REG_N_COAL_CHILD:       return m_n_child;
         REG_N_OVERFLOW:         return m_n_ovf;
         REG_N_CYCLES_DEQ_VALID: return m_n_dvc;
         default:                return '0;
      endcase
   endfunction

   task automatic add_row(input op_t op, input int n, input reg_addr_t adr, input reg_t val);
      row_t r;
      r.op  = op;
      r.n   = n[7:0];
      r.adr = adr;
      r.val = val;
      rows.push_back(r);
   endtask

   task automatic check_value(input string name, input task_t exp, input task_t got);
      n_checks++;
      assert (got === exp) else begin
         n_errors++;
         $display("Fail %s: expected %0h, got %0h", name, exp, got);
      end
   endtask

   task automatic push(input logic use_task, input logic use_child, input task_t t,
                       input task_t c);
      logic t_pend;
      logic c_pend;
      logic t_take;
      logic c_take;
      @(posedge clk);
      task_enq_valid   <= use_task;
      task_enq_data    <= t;
      coal_child_valid <= use_child;
      coal_child_data  <= c;
      t_pend = use_task;
      c_pend = use_child;
      while (t_pend || c_pend) begin
         @(negedge clk);
         t_take = t_pend && task_enq_ready;
         c_take = c_pend && coal_child_ready;
         @(posedge clk);
         if (t_take) begin
            task_enq_valid <= 1'b0;
            t_pend = 1'b0;
         end
         if (c_take) begin
            coal_child_valid <= 1'b0;
            c_pend = 1'b0;
         end
      end
   endtask

   // Pattern zero means random readies each cycle
   task automatic drain(input int n, input logic [2:0] pattern);
      int         target;
      logic [2:0] rdy;
      target = m_popped + n;
      forever begin
         @(posedge clk);
         if (m_popped >= target)
            break;
         rdy = pattern;
         if (pattern == 3'b000) begin
            rdy[0] = next_rand_bit();
            rdy[1] = next_rand_bit();
            rdy[2] = next_rand_bit();
         end
         task_deq_ready     <= rdy[0];
         splitter_deq_ready <= rdy[1];
         overflow_ready     <= rdy[2];
      end
      task_deq_ready     <= 1'b0;
      splitter_deq_ready <= 1'b0;
      overflow_ready     <= 1'b0;
   endtask

   task automatic bus_cycle(input logic we, input reg_addr_t adr, input reg_t wdata,
                            output reg_t rdata);
      @(posedge clk);
      wb_cyc   <= 1'b1;
      wb_stb   <= 1'b1;
      wb_we    <= we;
      wb_adr   <= adr;
      wb_wdata <= wdata;
      @(negedge clk);
      while (!wb_ack)
         @(negedge clk);
      rdata = wb_rdata;
      @(posedge clk);
      wb_cyc <= 1'b0;
      wb_stb <= 1'b0;
      wb_we  <= 1'b0;
   endtask

   task automatic run_row(input row_t r);
      reg_t  rdata;
      task_t t;
      task_t c;
      int    i;
      case (r.op)
         OP_PUSH, OP_CHILD, OP_BOTH: begin
            for (i = 0; i < r.n; i++) begin
               t = gen_word(r.val[i]);
               c = gen_word(1'b0);
               if (r.op == OP_CHILD)
                  push(1'b0, 1'b1, '0, t);
               else
                  push(1'b1, r.op == OP_BOTH, t, c);
            end
         end
         OP_DRAIN: drain(r.n, r.val[2:0]);
         OP_WRITE: bus_cycle(1'b1, r.adr, r.val, rdata);
         OP_READ: begin
            bus_cycle(1'b0, r.adr, '0, rdata);
            check_value("wb_rdata", r.val, rdata);
         end
         OP_READ_MODEL: begin
            bus_cycle(1'b0, r.adr, '0, rdata);
            check_value("wb_rdata", m_rd_exp, rdata);
         end
         default: ;
      endcase
   endtask

   // Predicts outputs for the coming edge, then applies its transfers
   always @(negedge clk) begin : model
      task_t head;
      logic  hv;
      logic  is_spl;
      logic  p_ovf;
      logic  p_deq;
      logic  p_spl;
      logic  p_full;
      logic  p_af;
      logic  p_enq_rdy;
      logic  pop_ovf;
      if (!rstn) begin
         m_q.delete();
         m_spill = 1'b0;
         m_left  = 0;
         m_thr   = 12;
         m_size  = 4;
         m_ack   = 1'b0;
         m_n_enq   = '0;
         m_n_child = '0;
         m_n_deq   = '0;
         m_n_spl   = '0;
         m_n_ovf   = '0;
         m_n_dvc   = '0;
      end else begin
         hv = (m_q.size() != 0);
         head = '0;
         if (hv)
            head = m_q[0];
         is_spl    = (head[71:68] == 4'hF);
         p_ovf     = hv && m_spill;
         p_deq     = hv && !m_spill && !is_spl;
         p_spl     = hv && !m_spill && is_spl;
         p_full    = (m_q.size() == 16);
         p_af      = (m_q.size() > m_thr);
         p_enq_rdy = !p_full && !p_af && !coal_child_valid;
         pop_ovf   = p_ovf && overflow_ready;
         check_value("overflow_valid", p_ovf, overflow_valid);
         check_value("task_deq_valid", p_deq, task_deq_valid);
         check_value("splitter_deq_valid", p_spl, splitter_deq_valid);
         if (p_ovf)
            check_value("overflow_data", head, overflow_data);
         if (p_deq)
            check_value("task_deq_data", head, task_deq_data);
         if (p_spl)
            check_value("splitter_deq_task", head, splitter_deq_task);
         check_value("task_enq_ready", p_enq_rdy, task_enq_ready);
         check_value("coal_child_ready", !p_full, coal_child_ready);
         check_value("full", p_full, full);
         check_value("almost_full", p_af, almost_full);
         check_value("empty", !hv, empty);
         check_value("wb_ack", m_ack, wb_ack);

         // Slave acks on the edge after a fresh strobe
         if (wb_cyc && wb_stb && !m_ack) begin
            if (wb_we && wb_adr == REG_SPILL_THRESHOLD)
               m_thr = wb_wdata[4:0];
            else if (wb_we && wb_adr == REG_SPILL_SIZE)
               m_size = wb_wdata[7:0];
            else if (!wb_we)
               m_rd_exp = model_reg(wb_adr);
            m_ack = 1'b1;
         end else begin
            m_ack = 1'b0;
         end

         if (p_deq)
            m_n_dvc++;
         if (pop_ovf || (p_deq && task_deq_ready) || (p_spl && splitter_deq_ready)) begin
            void'(m_q.pop_front());
            m_popped++;
            if (pop_ovf)
               m_n_ovf++;
            else if (p_deq)
               m_n_deq++;
            else
               m_n_spl++;
         end
         if (coal_child_valid && !p_full) begin
            m_q.push_back(coal_child_data);
            m_n_child++;
         end else if (task_enq_valid && p_enq_rdy) begin
            m_q.push_back(task_enq_data);
            m_n_enq++;
         end

         if (!m_spill && p_af && m_size != 0) begin
            m_spill = 1'b1;
            m_left  = m_size;
         end else if (m_spill && pop_ovf) begin
            m_left--;
            if (m_left == 0)
               m_spill = 1'b0;
         end
      end
   end

   initial begin : watchdog
      wait (rows_built);
      repeat (rows.size() * 64) @(posedge clk);
      n_errors++;
      $display("Timeout: stimulus table not finished after %0d cycles", rows.size() * 64);
      $display("Checks: %0d, errors: %0d", n_checks, n_errors);
      $display("TEST FAILED");
      $finish;
   end

   initial begin
      clk                = 1'b0;
      rstn               = 1'b0;
      task_enq_valid     = 1'b0;
      task_enq_data      = '0;
      coal_child_valid   = 1'b0;
      coal_child_data    = '0;
      task_deq_ready     = 1'b0;
      splitter_deq_ready = 1'b0;
      overflow_ready     = 1'b0;
      wb_cyc             = 1'b0;
      wb_stb             = 1'b0;
      wb_we              = 1'b0;
      wb_adr             = '0;
      wb_wdata           = '0;
      lfsr_state         = 32'h05e3_91cc;
      n_checks           = 0;
      n_errors           = 0;
      m_popped           = 0;
      rows_built         = 1'b0;

      // Reset values, then order and routing
      add_row(OP_READ, 0, REG_SPILL_THRESHOLD, 12);
      add_row(OP_READ, 0, REG_SPILL_SIZE, 4);
      add_row(OP_PUSH, 10, '0, 32'h0000_0259);
      add_row(OP_DRAIN, 10, '0, 0);
      add_row(OP_PUSH, 7, '0, 32'h0000_0046);
      add_row(OP_DRAIN, 4, '0, 0);
      add_row(OP_PUSH, 5, '0, 32'h0000_0011);
      add_row(OP_DRAIN, 8, '0, 0);
      // Coalescer priority
      add_row(OP_BOTH, 3, '0, 32'h0000_0002);
      add_row(OP_DRAIN, 6, '0, 0);
      // Spill of the three oldest
      add_row(OP_WRITE, 0, REG_SPILL_THRESHOLD, 5);
      add_row(OP_WRITE, 0, REG_SPILL_SIZE, 3);
      add_row(OP_READ, 0, REG_SPILL_THRESHOLD, 5);
      add_row(OP_READ, 0, REG_SPILL_SIZE, 3);
      add_row(OP_PUSH, 6, '0, 32'h0000_0024);
      add_row(OP_DRAIN, 6, '0, 7);
      add_row(OP_READ_MODEL, 0, REG_N_OVERFLOW, 0);
      // Full and empty
      add_row(OP_WRITE, 0, REG_SPILL_THRESHOLD, 16);
      add_row(OP_CHILD, 16, '0, 32'h0000_1081);
      add_row(OP_READ_MODEL, 0, REG_N_TASKS, 0);
      add_row(OP_DRAIN, 16, '0, 0);
      for (int a = 2; a <= 8; a++) begin
         add_row(OP_READ_MODEL, 0, reg_addr_t'(a), 0);
      end
      add_row(OP_READ, 0, 4'd9, 0);
      add_row(OP_READ, 0, 4'd15, 0);
      add_row(OP_WRITE, 0, 4'd11, 32'hffff_ffff);
      add_row(OP_READ, 0, REG_SPILL_THRESHOLD, 16);
      rows_built = 1'b1;

      repeat (4) @(posedge clk);
      rstn <= 1'b1;
      foreach (rows[i]) begin
         run_row(rows[i]);
      end
      @(posedge clk);
      $display("Checks: %0d, errors: %0d", n_checks, n_errors);
      if (n_errors == 0)
         $display("TEST PASSED");
      else
         $display("TEST FAILED");
      $finish;
   end

endmodule

//--- vlog.f
rtl/task_unit_pkg.sv
rtl/task_queue.sv
rtl/task_dispatch.sv
rtl/task_stats.sv
rtl/task_unit_csr.sv
rtl/task_unit.sv
test/task_unit_chk.sv
test/task_unit_tb.sv
